/* verilog/board_pkg.sv */
package board_pkg;

    // --------------------
    // Shared widths

    localparam int w_count      = 16;  // Lab counter width
    localparam int w_tm_digit   = 8;   // TM1638 digit positions
    localparam int w_tm_led     = 8;   // TM1638 LED positions
    localparam int n_hex_digits = 4;   // Digits 0..3 carry the count, LSD at 0

    // --------------------
    // TM1638 command bytes

    localparam logic [7:0] tm_cmd_write_auto = 8'h40;  // Data write, auto increment
    localparam logic [7:0] tm_cmd_addr0      = 8'hC0;  // Start at address 0
    localparam logic [7:0] tm_cmd_display_on = 8'h8F;  // Display on, full brightness

    // Bit 0 is segment a, bit 6 is segment g, bit 7 is the decimal point
    function automatic logic [7:0] hex_to_segments(input logic [3:0] value);
        case (value)
            4'h0: return 8'h3F;
            4'h1: return 8'h06;
            4'h2: return 8'h5B;
            4'h3: return 8'h4F;
            4'h4: return 8'h66;
            4'h5: return 8'h6D;
            4'h6: return 8'h7D;
            4'h7: return 8'h07;
            4'h8: return 8'h7F;
            4'h9: return 8'h6F;
            4'hA: return 8'h77;
            4'hB: return 8'h7C;
            4'hC: return 8'h39;
            4'hD: return 8'h5E;
            4'hE: return 8'h79;
            default: return 8'h71;  // F
        endcase
    endfunction

endpackage

/* verilog/slow_clk_gen.sv */
`timescale 1ns/10ps

module slow_clk_gen
#(
    parameter clk_mhz = 27,
    parameter tick_hz = 1
)
(
    input  logic clk,
    input  logic rst_n,
    output logic tick
);

    localparam int period = clk_mhz * 1000000 / tick_hz;  // Cycles between ticks
    localparam int w_cnt  = period > 1 ? $clog2(period) : 1;

    localparam logic [w_cnt-1:0] reload = w_cnt'(period - 1);

    logic [w_cnt-1:0] cnt;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            cnt  <= reload;
            tick <= 1'b0;
        end
        else if (cnt == '0)
        begin
            cnt  <= reload;              // Start the next period
            tick <= 1'b1;
        end
        else
        begin
            cnt  <= cnt - 1'b1;
            tick <= 1'b0;
        end
    end

    tick_single_cycle : assert property (
        @(posedge clk) disable iff (!rst_n)
        (period > 1) && tick |=> !tick
    );

endmodule

/* verilog/lab_top.sv */
`timescale 1ns/10ps

module lab_top
#(
    parameter w_led = 6
)
(
    input  logic                          clk,
    input  logic                          rst_n,

    input  logic                          tick,
    input  logic [1:0]                    key,          // Active high
    output logic [w_led-1:0]              led,          // Active high

    output logic                          frame_req,
    output logic [board_pkg::w_count-1:0] frame_count,
    input  logic                          frame_ack
);

    import board_pkg::*;

    logic [1:0]         key_meta;
    logic [1:0]         key_sync;
    logic [1:0]         key_prev;
    logic [1:0]         key_rise;

    logic               run;
    logic [w_count-1:0] count;

    logic               sent_once;
    logic               frame_start;

    // --------------------
    // Key synchronizer and edge detect

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            key_meta <= 2'b00;
            key_sync <= 2'b00;
            key_prev <= 2'b00;
        end
        else
        begin
            key_meta <= key;
            key_sync <= key_meta;
            key_prev <= key_sync;
        end
    end

    assign key_rise = key_sync & ~key_prev;

    // --------------------
    // Run flag and counter

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            run   <= 1'b1;
            count <= '0;
        end
        else
        begin
            if (key_rise[0])
                run <= ~run;                      // Pause toggles

            if (key_rise[1])
                count <= '0;                      // Clear wins over a tick
            else if (run && tick)
                count <= count + w_count'(1);     // Wraps at 16 bits
        end
    end

    assign led = count[w_led-1:0];

    // --------------------
    // Frame request side of the handshake

    // New frame on a changed count, or once after reset
    assign frame_start = !frame_req && !frame_ack
                         && (!sent_once || count != frame_count);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            frame_req <= 1'b0;
            sent_once <= 1'b0;
        end
        else if (frame_req)
        begin
            if (frame_ack)
                frame_req <= 1'b0;
        end
        else if (frame_start)
        begin
            frame_req <= 1'b1;
            sent_once <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (frame_start)
            frame_count <= count;                 // Held for the whole frame
    end

    frame_req_held : assert property (
        @(posedge clk) disable iff (!rst_n)
        frame_req && !frame_ack |=> frame_req && $stable(frame_count)
    );

endmodule

/* verilog/tm1638_sio_shifter.sv */
`timescale 1ns/10ps

module tm1638_sio_shifter
#(
    parameter sio_half_period = 8  // Two or more
)
(
    input  logic       clk,
    input  logic       rst_n,

    input  logic       byte_req,
    input  logic [7:0] byte_data,
    output logic       byte_ack,

    output logic       sio_clk,
    output logic       sio_dio
);

    localparam int w_half = sio_half_period > 1 ? $clog2(sio_half_period) : 1;

    localparam logic [w_half-1:0] half_last = w_half'(sio_half_period - 1);

    logic              busy;
    logic [2:0]        bit_cnt;
    logic [w_half-1:0] half_cnt;
    logic [7:0]        shift_q;
    logic              start;
    logic              bit_edge;

    assign start    = !busy && byte_req && !byte_ack;
    assign bit_edge = busy && !sio_clk && half_cnt == '0;  // One cycle into the low phase

    // --------------------
    // Clock phases and bit count

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            busy     <= 1'b0;
            byte_ack <= 1'b0;
            bit_cnt  <= '0;
            half_cnt <= '0;
            sio_clk  <= 1'b1;                   // Idle high
            sio_dio  <= 1'b1;
        end
        else if (start)
        begin
            busy     <= 1'b1;
            bit_cnt  <= '0;
            half_cnt <= '0;
            sio_clk  <= 1'b0;
        end
        else if (!busy)
        begin
            if (byte_ack && !byte_req)
                byte_ack <= 1'b0;
        end
        else if (!sio_clk)
        begin
            if (bit_edge)
                sio_dio <= shift_q[0];          // LSB first
            if (half_cnt == half_last)
            begin
                sio_clk  <= 1'b1;               // Device samples here
                half_cnt <= '0;
            end
            else
                half_cnt <= half_cnt + 1'b1;
        end
        else if (half_cnt != half_last)
            half_cnt <= half_cnt + 1'b1;
        else
        begin
            half_cnt <= '0;
            if (bit_cnt == 3'd7)
            begin
                busy     <= 1'b0;
                byte_ack <= 1'b1;
            end
            else
            begin
                bit_cnt <= bit_cnt + 1'b1;
                sio_clk <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (start)
            shift_q <= byte_data;
        else if (bit_edge)
            shift_q <= shift_q >> 1;
    end

    dio_stable_clk_high : assert property (
        @(posedge clk) disable iff (!rst_n)
        !$stable(sio_dio) |-> !sio_clk && !$past(sio_clk)
    );

endmodule

/* verilog/tm1638_board_controller.sv */
`timescale 1ns/10ps

module tm1638_board_controller
#(
    parameter w_led           = 6,
    parameter sio_half_period = 8
)
(
    input  logic                          clk,
    input  logic                          rst_n,

    input  logic                          frame_req,
    input  logic [board_pkg::w_count-1:0] frame_count,
    output logic                          frame_ack,

    input  logic [w_led-1:0]              led,

    output logic                          sio_stb,
    output logic                          sio_clk,
    output logic                          sio_dio
);

    import board_pkg::*;

    localparam int w_half = sio_half_period > 1 ? $clog2(sio_half_period) : 1;

    localparam logic [w_half-1:0] half_last = w_half'(sio_half_period - 1);

    // Byte index over the frame: 0x40, 0xC0, data bytes, 0x8F
    localparam logic [4:0] idx_addr      = 5'd1;
    localparam logic [4:0] idx_last_data = 5'(1 + 2 * w_tm_digit);
    localparam logic [4:0] idx_display   = 5'(2 + 2 * w_tm_digit);

    localparam logic [2:0] st_idle     = 3'd0;
    localparam logic [2:0] st_stb_low  = 3'd1;
    localparam logic [2:0] st_byte     = 3'd2;
    localparam logic [2:0] st_byte_end = 3'd3;
    localparam logic [2:0] st_stb_high = 3'd4;
    localparam logic [2:0] st_ack      = 3'd5;

    logic [2:0]         state;
    logic [4:0]         byte_idx;
    logic [w_half-1:0]  half_cnt;
    logic               byte_req;
    logic               byte_ack;
    logic [7:0]         byte_data;
    logic [4:0]         data_addr;

    logic [w_count-1:0] count_q;
    logic [w_led-1:0]   led_q;
    logic [7:0]         digit_byte [w_tm_digit];
    logic [7:0]         led_byte   [w_tm_led];

    // --------------------
    // Byte contents

    always_comb
    begin
        for (int k = 0; k < w_tm_digit; k++)
            digit_byte[k] = 8'h00;                // Blank positions
        for (int k = 0; k < n_hex_digits; k++)
            digit_byte[k] = hex_to_segments(count_q[4*k +: 4]);

        for (int k = 0; k < w_tm_led; k++)
            led_byte[k] = 8'h00;
        for (int k = 0; k < w_led && k < w_tm_led; k++)
            led_byte[k] = {7'b0, led_q[k]};
    end

    always_comb
    begin
        data_addr = byte_idx - 5'd2;              // Device address of a data byte

        if (byte_idx == 5'd0)
            byte_data = tm_cmd_write_auto;
        else if (byte_idx == idx_addr)
            byte_data = tm_cmd_addr0;
        else if (byte_idx == idx_display)
            byte_data = tm_cmd_display_on;
        else if (data_addr[0])
            byte_data = led_byte[data_addr[3:1]];   // Odd address is the LED
        else
            byte_data = digit_byte[data_addr[3:1]];
    end

    // --------------------
    // Frame sequencer

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state     <= st_idle;
            byte_idx  <= '0;
            half_cnt  <= '0;
            byte_req  <= 1'b0;
            sio_stb   <= 1'b1;
            frame_ack <= 1'b0;
        end
        else
        begin
            case (state)
                st_idle:
                    if (frame_req)
                    begin
                        byte_idx <= '0;
                        half_cnt <= '0;
                        sio_stb  <= 1'b0;
                        state    <= st_stb_low;
                    end
                st_stb_low:                          // Strobe setup before the first bit
                    if (half_cnt == half_last)
                    begin
                        byte_req <= 1'b1;
                        state    <= st_byte;
                    end
                    else
                        half_cnt <= half_cnt + 1'b1;
                st_byte:
                    if (byte_ack)
                    begin
                        byte_req <= 1'b0;
                        state    <= st_byte_end;
                    end
                st_byte_end:
                    if (!byte_ack)
                    begin
                        if (byte_idx == 5'd0 || byte_idx == idx_last_data
                            || byte_idx == idx_display)
                        begin
                            sio_stb  <= 1'b1;        // Group done
                            half_cnt <= '0;
                            state    <= st_stb_high;
                        end
                        else
                        begin
                            byte_idx <= byte_idx + 1'b1;
                            byte_req <= 1'b1;
                            state    <= st_byte;
                        end
                    end
                st_stb_high:
                    if (half_cnt != half_last)
                        half_cnt <= half_cnt + 1'b1;
                    else if (byte_idx == idx_display)
                    begin
                        frame_ack <= 1'b1;
                        state     <= st_ack;
                    end
                    else
                    begin
                        byte_idx <= byte_idx + 1'b1;
                        half_cnt <= '0;
                        sio_stb  <= 1'b0;
                        state    <= st_stb_low;
                    end
                st_ack:
                    if (!frame_req)
                    begin
                        frame_ack <= 1'b0;
                        state     <= st_idle;
                    end
                default:
                    state <= st_idle;
            endcase
        end
    end

    // Frame payload, sampled as the frame starts
    always_ff @(posedge clk)
    begin
        if (state == st_idle && frame_req)
        begin
            count_q <= frame_count;
            led_q   <= led;
        end
    end

    // --------------------

    tm1638_sio_shifter
    #(
        .sio_half_period ( sio_half_period )
    )
    i_sio_shifter
    (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .byte_req  ( byte_req  ),
        .byte_data ( byte_data ),
        .byte_ack  ( byte_ack  ),
        .sio_clk   ( sio_clk   ),
        .sio_dio   ( sio_dio   )
    );

    stb_quiet_during_byte : assert property (
        @(posedge clk) disable iff (!rst_n)
        !$stable(sio_stb) |-> !byte_req && !$past(byte_req)
    );

endmodule

/* verilog/board_specific_top.sv */
`timescale 1ns/10ps

module board_specific_top
#(
    parameter clk_mhz         = 27,
    parameter tick_hz         = 1,
    parameter w_led           = 6,
    parameter sio_half_period = 8
)
(
    input  logic             clk,
    input  logic             rst_n,

    input  logic [1:0]       key,      // Active low on the board
    output logic [w_led-1:0] led,      // Active low on the board

    output logic             sio_clk,
    output logic             sio_stb,
    output logic             sio_dio
);

    import board_pkg::*;

    logic [1:0]         lab_key;
    logic [w_led-1:0]   lab_led;
    logic               tick;
    logic               frame_req;
    logic               frame_ack;
    logic [w_count-1:0] frame_count;

    // --------------------
    // Board wiring polarity

    assign lab_key = ~key;
    assign led     = ~lab_led;

    // --------------------

    slow_clk_gen
    #(
        .clk_mhz ( clk_mhz ),
        .tick_hz ( tick_hz )
    )
    i_slow_clk_gen
    (
        .clk   ( clk   ),
        .rst_n ( rst_n ),
        .tick  ( tick  )
    );

    // --------------------

    lab_top
    #(
        .w_led ( w_led )
    )
    i_lab_top
    (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .tick        ( tick        ),
        .key         ( lab_key     ),
        .led         ( lab_led     ),
        .frame_req   ( frame_req   ),
        .frame_count ( frame_count ),
        .frame_ack   ( frame_ack   )
    );

    // --------------------

    tm1638_board_controller
    #(
        .w_led           ( w_led           ),
        .sio_half_period ( sio_half_period )
    )
    i_tm1638
    (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .frame_req   ( frame_req   ),
        .frame_count ( frame_count ),
        .frame_ack   ( frame_ack   ),
        .led         ( lab_led     ),
        .sio_stb     ( sio_stb     ),
        .sio_clk     ( sio_clk     ),
        .sio_dio     ( sio_dio     )
    );

endmodule

/* bench/tm1638_monitor.sv */
`timescale 1ns/10ps

module tm1638_monitor
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        sio_clk,
    input  logic        sio_stb,
    input  logic        sio_dio,

    output logic        frame_start,    // First strobe of a frame went low
    output logic        frame_done,     // Display-on group closed
    output logic [7:0]  cmd_byte,
    output logic [7:0]  addr_byte,
    output logic [7:0]  disp_byte,
    output logic [7:0]  data_len,
    output logic [15:0] value,
    output logic [7:0]  led_bits,
    output logic [7:0]  blank_or,
    output logic        font_ok
);

    logic       clk_prev;
    logic       stb_prev;
    logic [7:0] shift;
    int         nbits;
    int         group;
    logic [7:0] bytes [$];

    // Returns {valid, nibble}
    function automatic logic [4:0] decode_segments(input logic [7:0] seg);
        case (seg)
            8'h3F: return 5'h10;
            8'h06: return 5'h11;
            8'h5B: return 5'h12;
            8'h4F: return 5'h13;
            8'h66: return 5'h14;
            8'h6D: return 5'h15;
            8'h7D: return 5'h16;
            8'h07: return 5'h17;
            8'h7F: return 5'h18;
            8'h6F: return 5'h19;
            8'h77: return 5'h1A;
            8'h7C: return 5'h1B;
            8'h39: return 5'h1C;
            8'h5E: return 5'h1D;
            8'h79: return 5'h1E;
            8'h71: return 5'h1F;
            default: return 5'h00;
        endcase
    endfunction

    task close_group();
        string       text;
        logic [4:0]  dec;
        logic        ok;
        logic [15:0] val;
        logic [7:0]  leds;
        logic [7:0]  blank;
        text = "";
        foreach (bytes[i])
            text = {text, $sformatf(" %h", bytes[i])};
        $display("monitor: group %0d bytes%s", group, text);
        if (group == 0 && bytes.size() > 0)
            cmd_byte <= bytes[0];
        if (group == 1 && bytes.size() > 0)
        begin
            addr_byte <= bytes[0];
            data_len  <= 8'(bytes.size() - 1);
            ok    = (bytes.size() == 17);
            val   = '0;
            leds  = '0;
            blank = '0;
            for (int k = 0; k < 8 && ok; k++)
            begin
                if (k < 4)
                begin
                    dec = decode_segments(bytes[1 + 2*k]);
                    ok  = ok & dec[4];
                    val[4*k +: 4] = dec[3:0];
                end
                else
                    blank = blank | bytes[1 + 2*k];   // Unused digit positions
                leds[k] = bytes[2 + 2*k][0];
            end
            font_ok  <= ok;
            value    <= val;
            led_bits <= leds;
            blank_or <= blank;
        end
        if (group == 2)
        begin
            if (bytes.size() > 0)
                disp_byte <= bytes[0];
            frame_done <= 1'b1;
            $display("monitor: frame value %h, led bits %b", value, led_bits);
        end
        group = (group + 1) % 3;
    endtask

    always @(posedge clk)
    begin
        frame_start <= 1'b0;
        frame_done  <= 1'b0;
        if (!rst_n)
        begin
            clk_prev = 1'b1;
            stb_prev = 1'b1;
            shift    = '0;
            nbits    = 0;
            group    = 0;
            bytes.delete();
        end
        else
        begin
            if (stb_prev && !sio_stb)
            begin
                bytes.delete();
                nbits = 0;
                if (group == 0)
                    frame_start <= 1'b1;
            end
            if (!sio_stb && sio_clk && !clk_prev)
            begin
                shift = {sio_dio, shift[7:1]};          // LSB arrives first
                nbits++;
                if (nbits == 8)
                begin
                    bytes.push_back(shift);
                    nbits = 0;
                end
            end
            if (!stb_prev && sio_stb)
                close_group();
            clk_prev = sio_clk;
            stb_prev = sio_stb;
        end
    end

endmodule

/* bench/tb_board_top.sv */
`timescale 1ns/10ps

module tb_board_top;

    localparam int w_led         = 6;
    localparam int frame_timeout = 4000;   // Cycles for a frame in flight plus one

    logic             clk;
    logic             rst_n;
    logic [1:0]       key;
    logic [w_led-1:0] led;
    logic             sio_clk;
    logic             sio_stb;
    logic             sio_dio;

    logic             frame_start;
    logic             frame_done;
    logic [7:0]       cmd_byte;
    logic [7:0]       addr_byte;
    logic [7:0]       disp_byte;
    logic [7:0]       data_len;
    logic [15:0]      value;
    logic [7:0]       led_bits;
    logic [7:0]       blank_or;
    logic             font_ok;

    int               errors = 0;
    int               serial_errors = 0;
    int               tests_run = 0;
    int               errors_at_start = 0;
    int               seed = 79111;
    int               cyc = 0;

    logic             paused_ref;
    logic             clear_window;
    logic             value_armed;
    logic             zero_armed;
    logic             key1_q;
    logic [w_led-1:0] led_q;
    logic [w_led-1:0] led_next;
    logic [w_led-1:0] lab_led;

    assign lab_led  = ~led;
    assign led_next = led_after_tick(led_q);

    // Board LED pattern one count later, active low
    function automatic logic [w_led-1:0] led_after_tick(input logic [w_led-1:0] board_led);
        logic [w_led-1:0] lab;
        lab = ~board_led;
        return ~(lab + 1'b1);                 // Wraps at w_led bits
    endfunction

    board_specific_top
    #(
        .clk_mhz         ( 1      ),
        .tick_hz         ( 100000 ),
        .w_led           ( w_led  ),
        .sio_half_period ( 2      )
    )
    uut
    (
        .clk     ( clk     ),
        .rst_n   ( rst_n   ),
        .key     ( key     ),
        .led     ( led     ),
        .sio_clk ( sio_clk ),
        .sio_stb ( sio_stb ),
        .sio_dio ( sio_dio )
    );

    tm1638_monitor i_monitor
    (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .sio_clk     ( sio_clk     ),
        .sio_stb     ( sio_stb     ),
        .sio_dio     ( sio_dio     ),
        .frame_start ( frame_start ),
        .frame_done  ( frame_done  ),
        .cmd_byte    ( cmd_byte    ),
        .addr_byte   ( addr_byte   ),
        .disp_byte   ( disp_byte   ),
        .data_len    ( data_len    ),
        .value       ( value       ),
        .led_bits    ( led_bits    ),
        .blank_or    ( blank_or    ),
        .font_ok     ( font_ok     )
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cyc    <= cyc + 1;
        key1_q <= key[1];
        led_q  <= led;
    end

    // --------------------
    // Checks

    // Edges 2 to 7 see the reset values and the first cycle after reset
    reset_state : assert property (@(posedge clk)
        cyc >= 1 && cyc <= 6 |-> led == '1 && sio_stb && sio_clk)
        else
        begin
            $display("ERROR reset state: led %h sio_stb %h sio_clk %h, expected %h 1 1",
                     led, sio_stb, sio_clk, {w_led{1'b1}});
            errors++;
        end

    led_steps : assert property (@(posedge clk) disable iff (!rst_n)
        led != led_q && !clear_window |-> led == led_next)
        else
        begin
            $display("ERROR led: got %h, expected %h", led, led_next);
            errors++;
        end

    paused_hold : assert property (@(posedge clk) disable iff (!rst_n)
        paused_ref && !clear_window |-> led == led_q)
        else
        begin
            $display("ERROR led: got %h while paused, expected %h", led, led_q);
            errors++;
        end

    clear_led : assert property (@(posedge clk) disable iff (!rst_n)
        key1_q && !key[1] |-> ##[0:4] led == '1)
        else
        begin
            $display("ERROR led: got %h after clear, expected %h", led, {w_led{1'b1}});
            errors++;
        end

    frame_cmds : assert property (@(posedge clk) disable iff (!rst_n)
        frame_done |-> cmd_byte == 8'h40 && addr_byte == 8'hC0 && disp_byte == 8'h8F)
        else
        begin
            $display("ERROR cmd_byte addr_byte disp_byte: got %h %h %h, expected 40 c0 8f",
                     cmd_byte, addr_byte, disp_byte);
            errors++;
        end

    frame_length : assert property (@(posedge clk) disable iff (!rst_n)
        frame_done |-> data_len == 8'd16)
        else
        begin
            $display("ERROR data_len: got %h, expected %h", data_len, 8'd16);
            errors++;
        end

    frame_blank : assert property (@(posedge clk) disable iff (!rst_n)
        frame_done |-> blank_or == 8'h00)
        else
        begin
            $display("ERROR blank_or: got %h, expected %h", blank_or, 8'h00);
            errors++;
        end

    frame_font : assert property (@(posedge clk) disable iff (!rst_n)
        frame_done |-> font_ok)
        else
        begin
            $display("A digit byte in the frame is not a hex font entry");
            errors++;
        end

    frame_value : assert property (@(posedge clk) disable iff (!rst_n)
        frame_done && value_armed |-> value[w_led-1:0] == lab_led
                                      && led_bits == 8'(lab_led))
        else
        begin
            $display("ERROR value: got %h led_bits %h, expected %h led_bits %h",
                     value[w_led-1:0], led_bits, lab_led, 8'(lab_led));
            errors++;
        end

    frame_zero : assert property (@(posedge clk) disable iff (!rst_n)
        frame_done && zero_armed |-> value == 16'h0000)
        else
        begin
            $display("ERROR value: got %h after clear, expected %h", value, 16'h0000);
            errors++;
        end

    dio_quiet : assert property (@(posedge clk) disable iff (!rst_n)
        !$stable(sio_dio) |-> !sio_clk && !$past(sio_clk))
        else
        begin
            $display("sio_dio changed while sio_clk was high");
            errors++;
            serial_errors++;
        end

    stb_quiet : assert property (@(posedge clk) disable iff (!rst_n)
        !$stable(sio_stb) |-> sio_clk && $past(sio_clk))
        else
        begin
            $display("sio_stb changed while sio_clk was low");
            errors++;
            serial_errors++;
        end

    // --------------------
    // Stimulus helpers

    task automatic press_key(input int idx);
        key[idx] = 1'b0;                      // Board keys are active low
        repeat (2) @(posedge clk);
        #1;
        key[idx] = 1'b1;
    endtask

    task automatic random_delay(input int lo, input int span);
        repeat (lo + {$random(seed)} % span) @(posedge clk);
        #1;
    endtask

    task automatic wait_frame_event(input bit until_done);
        int waited;
        waited = 0;
        do
        begin
            @(posedge clk);
            #1;
            waited++;
        end
        while (!(until_done ? frame_done : frame_start) && waited < frame_timeout);
        if (!(until_done ? frame_done : frame_start))
        begin
            $display("Timeout: no frame %s within %0d cycles",
                     until_done ? "end" : "start", frame_timeout);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int failures);
        tests_run++;
        $display("test %0d %s: %s", tests_run, name, failures == 0 ? "ok" : "FAILED");
        errors_at_start = errors;
    endtask

    // --------------------
    // Test sequence

    initial
    begin
        key          = 2'b11;
        rst_n        = 1'b0;
        paused_ref   = 1'b0;
        clear_window = 1'b0;
        value_armed  = 1'b0;
        zero_armed   = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        finish_test("reset state", errors - errors_at_start);

        wait_frame_event(1'b1);
        wait_frame_event(1'b1);
        finish_test("frame format", errors - errors_at_start);

        for (int i = 0; i < 3; i++)
        begin
            random_delay(50, 200);
            press_key(0);                     // Pause
            repeat (2) @(posedge clk);
            #1;
            paused_ref = 1'b1;
            random_delay(30, 150);
            paused_ref = 1'b0;
            press_key(0);                     // Resume
        end
        finish_test("counting and pause", errors - errors_at_start);

        wait_frame_event(1'b0);
        random_delay(20, 180);                // Pause lands inside this frame
        press_key(0);
        repeat (2) @(posedge clk);
        #1;
        paused_ref = 1'b1;
        wait_frame_event(1'b0);
        value_armed = 1'b1;
        wait_frame_event(1'b1);
        @(posedge clk);
        #1;
        value_armed = 1'b0;
        finish_test("frame value after pause", errors - errors_at_start);

        clear_window = 1'b1;
        press_key(1);                         // Clear while paused
        repeat (3) @(posedge clk);
        #1;
        clear_window = 1'b0;
        wait_frame_event(1'b0);
        zero_armed = 1'b1;
        wait_frame_event(1'b1);
        @(posedge clk);
        #1;
        zero_armed = 1'b0;
        paused_ref = 1'b0;
        press_key(0);
        random_delay(100, 100);
        clear_window = 1'b1;
        press_key(1);                         // Clear while running
        repeat (3) @(posedge clk);
        #1;
        clear_window = 1'b0;
        finish_test("clear", errors - errors_at_start);

        wait_frame_event(1'b1);
        finish_test("serial timing", serial_errors);

        $display("tests run: %0d, failed checks: %0d", tests_run, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

/* vlog.f */
verilog/board_pkg.sv
verilog/slow_clk_gen.sv
verilog/lab_top.sv
verilog/tm1638_sio_shifter.sv
verilog/tm1638_board_controller.sv
verilog/board_specific_top.sv
bench/tm1638_monitor.sv
bench/tb_board_top.sv
